//--- hw/bank_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module bank_dispatch (
    input  logic                                mem_wr_if_in,
    input  logic                                addr_reset,

    // Application requests
    input  logic                                wr_req,
    input  logic [mem_cfg_pkg::ADDR_WID-1:0]    wr_addr,
    input  logic [mem_cfg_pkg::DATA_WID-1:0]    wr_data,
    input  logic                                rd_req,
    input  logic [mem_cfg_pkg::ADDR_WID-1:0]    rd_addr,

    // Per-bank strobes and shared buses
    output logic [mem_cfg_pkg::NUM_BANKS-1:0]   bank_wr_req,
    output logic [mem_cfg_pkg::NUM_BANKS-1:0]   bank_rd_req,
    output logic [mem_cfg_pkg::ROW_WID-1:0]     row_wr,
    output logic [mem_cfg_pkg::DATA_WID-1:0]    data_wr,
    output logic [mem_cfg_pkg::ROW_WID-1:0]     row_rd
);
    import mem_cfg_pkg::*;

    logic [BANK_BITS-1:0] wr_bank;
    logic [BANK_BITS-1:0] rd_bank;

    // One-hot bank select from the bank field
    function automatic logic [NUM_BANKS-1:0] bank_sel(input logic [BANK_BITS-1:0] bank);
        logic [NUM_BANKS-1:0] sel;
        sel       = '0;
        sel[bank] = 1'b1;
        return sel;
    endfunction

    // ----------------------------------------
    // Address split
    // ----------------------------------------
    assign wr_bank = wr_addr[ADDR_WID-1 -: BANK_BITS];
    assign rd_bank = rd_addr[ADDR_WID-1 -: BANK_BITS];

    // Strobes, one bank at most per direction
    always_ff @(posedge mem_wr_if_in) begin
        if (addr_reset) begin
            bank_wr_req <= '0;
            bank_rd_req <= '0;
        end else begin
            bank_wr_req <= wr_req ? bank_sel(wr_bank) : '0;
            bank_rd_req <= rd_req ? bank_sel(rd_bank) : '0;
        end
    end

    // Row and data go to every bank, only the strobe differs
    always_ff @(posedge mem_wr_if_in) begin
        if (wr_req) begin
            row_wr  <= wr_addr[ROW_WID-1:0];
            data_wr <= wr_data;
        end
        if (rd_req) begin
            row_rd <= rd_addr[ROW_WID-1:0];
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    // A request never reaches two banks at once
    a_strobe_onehot : assert property (@(posedge mem_wr_if_in) disable iff (addr_reset)
        $onehot0(bank_wr_req) && $onehot0(bank_rd_req))
        else $error("bank_dispatch: strobe vector not one-hot");

endmodule : bank_dispatch

`default_nettype wire

//--- hw/bank_merge.sv
`timescale 1ns/1ps
`default_nettype none

module bank_merge (
    input  logic                                mem_wr_if_in,
    input  logic                                addr_reset,

    // Per-bank responses
    input  logic [mem_cfg_pkg::NUM_BANKS-1:0]   bank_wr_ack,
    input  logic [mem_cfg_pkg::NUM_BANKS-1:0]   bank_rd_valid,
    input  logic [mem_cfg_pkg::NUM_BANKS-1:0][mem_cfg_pkg::DATA_WID-1:0] bank_rd_data,
    input  logic [mem_cfg_pkg::NUM_BANKS-1:0]   bank_ready,

    // Array responses
    output logic                                wr_ack,
    output logic                                rd_valid,
    output logic [mem_cfg_pkg::DATA_WID-1:0]    rd_data,
    output logic                                ready
);
    import mem_cfg_pkg::*;

    logic [DATA_WID-1:0] rd_sel;
    logic                rd_any;

    // ----------------------------------------
    // Read data select
    // ----------------------------------------
    // AND-OR mux on the one-hot valid
    always_comb begin
        rd_sel = '0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            rd_sel = rd_sel | (bank_rd_data[b] & {DATA_WID{bank_rd_valid[b]}});
        end
    end

    assign rd_any = |bank_rd_valid;

    // Output registers
    always_ff @(posedge mem_wr_if_in) begin
        if (addr_reset) begin
            wr_ack   <= 1'b0;
            rd_valid <= 1'b0;
            ready    <= 1'b0;
        end else begin
            wr_ack   <= |bank_wr_ack;
            rd_valid <= rd_any;
            // Array is ready once every bank finished its walk
            ready    <= &bank_ready;
        end
    end

    always_ff @(posedge mem_wr_if_in) begin
        if (rd_any) begin
            rd_data <= rd_sel;
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    // One-hot dispatch must keep bank responses apart
    a_rd_valid_onehot : assert property (@(posedge mem_wr_if_in) disable iff (addr_reset)
        $onehot0(bank_rd_valid))
        else $error("bank_merge: more than one bank returned read data");

endmodule : bank_merge

`default_nettype wire

//--- hw/mem_bank.sv
`timescale 1ns/1ps
`default_nettype none

module mem_bank #(
    parameter mem_ctrl_pkg::opt_mode_t OPT_MODE = mem_ctrl_pkg::OPT_MODE_TIMING
) (
    input  logic                                mem_wr_if_in,
    input  logic                                addr_reset,
    input  logic                                wr_req,
    input  logic                                rd_req,
    input  logic [mem_cfg_pkg::ROW_WID-1:0]     row_wr,
    input  logic [mem_cfg_pkg::DATA_WID-1:0]    data_wr,
    input  logic [mem_cfg_pkg::ROW_WID-1:0]     row_rd,
    output logic                                wr_ack,
    output logic                                rd_valid,
    output logic [mem_cfg_pkg::DATA_WID-1:0]    rd_data,
    output logic                                bank_ready
);
    import mem_cfg_pkg::*;
    import mem_ctrl_pkg::*;

    logic                 wr_req_q;
    logic [ROW_WID-1:0]   row_wr_q;
    logic [DATA_WID-1:0]  data_wr_q;

    logic                 ram_rdy;
    logic                 ram_ack;
    logic                 ram_wr_en;
    logic [ROW_WID-1:0]   ram_row;
    logic [DATA_WID-1:0]  ram_data;
    logic [DATA_WID-1:0]  mem [ROWS];
    logic [DATA_WID-1:0]  ram_q;
    logic                 rd_pend;

    // Write staging ahead of the init mux
    always_ff @(posedge mem_wr_if_in) begin
        if (addr_reset) begin
            wr_req_q <= 1'b0;
        end else begin
            wr_req_q <= wr_req;
        end
    end

    always_ff @(posedge mem_wr_if_in) begin
        if (wr_req) begin
            row_wr_q  <= row_wr;
            data_wr_q <= data_wr;
        end
    end

    mem_reset_fsm #(
        .OPT_MODE   (OPT_MODE)
    ) mem_reset_fsm_inst (
        .mem_wr_if_in   (mem_wr_if_in),
        .addr_reset     (addr_reset),
        .app_wr_req     (wr_req_q),
        .app_row        (row_wr_q),
        .app_data       (data_wr_q),
        .app_wr_ack     (wr_ack),
        .bank_ready     (bank_ready),
        .ram_rdy        (ram_rdy),
        .ram_ack        (ram_ack),
        .ram_wr_en      (ram_wr_en),
        .ram_row        (ram_row),
        .ram_data       (ram_data)
    );

    // ----------------------------------------
    // Storage
    // ----------------------------------------
    always_ff @(posedge mem_wr_if_in) begin
        if (addr_reset) begin
            ram_rdy <= 1'b0;
            ram_ack <= 1'b0;
        end else begin
            ram_rdy <= 1'b1;
            ram_ack <= ram_wr_en;
        end
    end

    // Read-first, so a same-edge write is not seen
    always_ff @(posedge mem_wr_if_in) begin
        if (ram_wr_en) begin
            mem[ram_row] <= ram_data;
        end
        if (rd_req) begin
            ram_q <= mem[row_rd];
        end
    end

    // Reads taken before init are dropped here
    always_ff @(posedge mem_wr_if_in) begin
        if (addr_reset) begin
            rd_pend  <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            rd_pend  <= rd_req & bank_ready;
            rd_valid <= rd_pend;
        end
    end

    always_ff @(posedge mem_wr_if_in) begin
        if (rd_pend) begin
            rd_data <= ram_q;
        end
    end

    // Storage writes only from the clear walk or after init
    a_wr_when_rdy : assert property (@(posedge mem_wr_if_in) disable iff (addr_reset)
        ram_wr_en |-> ram_rdy &&
            (bank_ready || mem_reset_fsm_inst.state inside {CLEAR, CLEAR_DONE}))
        else $error("mem_bank: storage written outside clear walk or before ready");

endmodule : mem_bank

`default_nettype wire

//--- hw/mem_bank_array.sv
`timescale 1ns/1ps
`default_nettype none

module mem_bank_array #(
    parameter mem_ctrl_pkg::opt_mode_t OPT_MODE = mem_ctrl_pkg::OPT_MODE_TIMING
) (
    input  logic                                mem_wr_if_in,
    input  logic                                addr_reset,
    input  logic                                wr_req,
    input  logic [mem_cfg_pkg::ADDR_WID-1:0]    wr_addr,
    input  logic [mem_cfg_pkg::DATA_WID-1:0]    wr_data,
    input  logic                                rd_req,
    input  logic [mem_cfg_pkg::ADDR_WID-1:0]    rd_addr,
    output logic                                wr_ack,
    output logic                                rd_valid,
    output logic [mem_cfg_pkg::DATA_WID-1:0]    rd_data,
    output logic                                ready
);
    import mem_cfg_pkg::*;

    // Dispatcher to banks
    logic [NUM_BANKS-1:0]                 bank_wr_req;
    logic [NUM_BANKS-1:0]                 bank_rd_req;
    logic [ROW_WID-1:0]                   row_wr;
    logic [DATA_WID-1:0]                  data_wr;
    logic [ROW_WID-1:0]                   row_rd;

    // Banks to merge
    logic [NUM_BANKS-1:0]                 bank_wr_ack;
    logic [NUM_BANKS-1:0]                 bank_rd_valid;
    logic [NUM_BANKS-1:0][DATA_WID-1:0]   bank_rd_data;
    logic [NUM_BANKS-1:0]                 bank_ready;

    bank_dispatch bank_dispatch_inst (
        .mem_wr_if_in   (mem_wr_if_in),
        .addr_reset     (addr_reset),
        .wr_req         (wr_req),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .rd_req         (rd_req),
        .rd_addr        (rd_addr),
        .bank_wr_req    (bank_wr_req),
        .bank_rd_req    (bank_rd_req),
        .row_wr         (row_wr),
        .data_wr        (data_wr),
        .row_rd         (row_rd)
    );

    // ----------------------------------------
    // Banks
    // ----------------------------------------
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        mem_bank #(
            .OPT_MODE   (OPT_MODE)
        ) mem_bank_inst (
            .mem_wr_if_in   (mem_wr_if_in),
            .addr_reset     (addr_reset),
            .wr_req         (bank_wr_req[b]),
            .rd_req         (bank_rd_req[b]),
            .row_wr         (row_wr),
            .data_wr        (data_wr),
            .row_rd         (row_rd),
            .wr_ack         (bank_wr_ack[b]),
            .rd_valid       (bank_rd_valid[b]),
            .rd_data        (bank_rd_data[b]),
            .bank_ready     (bank_ready[b])
        );
    end : g_bank

    bank_merge bank_merge_inst (
        .mem_wr_if_in   (mem_wr_if_in),
        .addr_reset     (addr_reset),
        .bank_wr_ack    (bank_wr_ack),
        .bank_rd_valid  (bank_rd_valid),
        .bank_rd_data   (bank_rd_data),
        .bank_ready     (bank_ready),
        .wr_ack         (wr_ack),
        .rd_valid       (rd_valid),
        .rd_data        (rd_data),
        .ready          (ready)
    );

endmodule : mem_bank_array

`default_nettype wire

//--- hw/mem_cfg_pkg.sv
`default_nettype none

package mem_cfg_pkg;

    // ----------------------------------------
    // Address geometry
    // ----------------------------------------
    // Application word address
    localparam int ADDR_WID  = 8;

    // High address bits pick the bank
    localparam int BANK_BITS = 2;
    localparam int NUM_BANKS = 2 ** BANK_BITS;

    // Low address bits pick the row inside a bank
    localparam int ROW_WID   = ADDR_WID - BANK_BITS;
    localparam int ROWS      = 2 ** ROW_WID;

    // ----------------------------------------
    // Data
    // ----------------------------------------
    localparam int DATA_WID  = 16;

    // Written to every entry by the clear walk
    localparam logic [DATA_WID-1:0] RESET_VAL = 16'h0000;

endpackage : mem_cfg_pkg

`default_nettype wire

//--- hw/mem_ctrl_pkg.sv
`default_nettype none

package mem_ctrl_pkg;

    // ----------------------------------------
    // Write path pipelining
    // ----------------------------------------
    // TIMING registers the write path after the init mux,
    // LATENCY leaves it combinational
    typedef enum logic {
        OPT_MODE_TIMING,
        OPT_MODE_LATENCY
    } opt_mode_t;

    // ----------------------------------------
    // Per-bank init sequence
    // ----------------------------------------
    // RESET       wait for storage ready
    // CLEAR       walk all rows writing the reset value
    // CLEAR_DONE  let the last clear acks drain
    // INIT_DONE   bank open for application traffic
    typedef enum logic [1:0] {
        RESET,
        CLEAR,
        CLEAR_DONE,
        INIT_DONE
    } init_state_t;

endpackage : mem_ctrl_pkg

`default_nettype wire

//--- hw/mem_reset_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module mem_reset_fsm #(
    parameter mem_ctrl_pkg::opt_mode_t OPT_MODE = mem_ctrl_pkg::OPT_MODE_TIMING
) (
    input  logic                                mem_wr_if_in,
    input  logic                                addr_reset,

    // Application write side
    input  logic                                app_wr_req,
    input  logic [mem_cfg_pkg::ROW_WID-1:0]     app_row,
    input  logic [mem_cfg_pkg::DATA_WID-1:0]    app_data,
    output logic                                app_wr_ack,
    output logic                                bank_ready,

    // Storage side
    input  logic                                ram_rdy,
    input  logic                                ram_ack,
    output logic                                ram_wr_en,
    output logic [mem_cfg_pkg::ROW_WID-1:0]     ram_row,
    output logic [mem_cfg_pkg::DATA_WID-1:0]    ram_data
);
    import mem_cfg_pkg::*;
    import mem_ctrl_pkg::*;

    init_state_t          state;
    init_state_t          state_nxt;
    logic                 row_clr;
    logic [ROW_WID-1:0]   clr_row;
    logic                 init_done;

    // ----------------------------------------
    // Init sequence
    // ----------------------------------------
    always_ff @(posedge mem_wr_if_in) begin
        if (addr_reset) begin
            state <= RESET;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        row_clr   = 1'b1;
        init_done = 1'b0;
        case (state)
            RESET: begin
                if (ram_rdy) begin
                    state_nxt = CLEAR;
                end
            end
            CLEAR: begin
                row_clr = 1'b0;
                if (clr_row == ROW_WID'(ROWS - 1)) begin
                    state_nxt = CLEAR_DONE;
                end
            end
            CLEAR_DONE: begin
                // Acks of the clear writes must not leak out
                if (!ram_ack) begin
                    state_nxt = INIT_DONE;
                end
            end
            INIT_DONE: begin
                init_done = 1'b1;
            end
            default: begin
                state_nxt = RESET;
            end
        endcase
    end

    // Row walk, held at zero outside CLEAR
    always_ff @(posedge mem_wr_if_in) begin
        if (row_clr) begin
            clr_row <= '0;
        end else begin
            clr_row <= clr_row + 1'b1;
        end
    end

    always_ff @(posedge mem_wr_if_in) begin
        if (addr_reset) begin
            bank_ready <= 1'b0;
        end else begin
            bank_ready <= init_done;
        end
    end

    // Only writes issued after init are acknowledged
    assign app_wr_ack = bank_ready ? ram_ack : 1'b0;

    // ----------------------------------------
    // Write path mux
    // ----------------------------------------
    generate
        if (OPT_MODE == OPT_MODE_TIMING) begin : g_wr_pipe
            always_ff @(posedge mem_wr_if_in) begin
                if (addr_reset) begin
                    ram_wr_en <= 1'b0;
                end else begin
                    ram_wr_en <= bank_ready ? app_wr_req : (state == CLEAR);
                end
            end

            always_ff @(posedge mem_wr_if_in) begin
                ram_row  <= bank_ready ? app_row : clr_row;
                ram_data <= bank_ready ? app_data : RESET_VAL;
            end
        end : g_wr_pipe
        else begin : g_wr_comb
            assign ram_wr_en = bank_ready ? app_wr_req : (state == CLEAR);
            assign ram_row   = bank_ready ? app_row : clr_row;
            assign ram_data  = bank_ready ? app_data : RESET_VAL;
        end : g_wr_comb
    endgenerate

    // Every acked write entered the path after init
    a_ack_after_ready : assert property (@(posedge mem_wr_if_in) disable iff (addr_reset)
        app_wr_ack |-> $past(bank_ready))
        else $error("mem_reset_fsm: write ack while bank not ready");

endmodule : mem_reset_fsm

`default_nettype wire

//--- verif/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset held over RESET_CYCLES rising edges, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst <= 1'b0;
    end

endmodule : tb_clock_gen

`default_nettype wire

//--- verif/tb_mem_bank_array.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_bank_array;
    import mem_cfg_pkg::*;
    import mem_ctrl_pkg::*;

    localparam opt_mode_t MODE = OPT_MODE_TIMING;

    // Latencies in edges, counted from the edge that samples the strobe
    localparam int WR_ACK_LAT  = (MODE == OPT_MODE_TIMING) ? 4 : 3;
    localparam int RD_LAT      = 3;
    localparam int RAW_GAP     = (MODE == OPT_MODE_TIMING) ? 3 : 2;

    localparam int RESET_CYC   = 2;
    localparam int INIT_BUDGET = 100;
    localparam int N_DROP      = 4;
    localparam int N_CLEAR_RD  = 16;
    localparam int N_WR_RD     = 24;
    localparam int N_MIX       = 64;
    localparam int N_OPS       = 2 * N_DROP + N_CLEAR_RD + N_DROP + 2 * N_WR_RD + N_MIX;
    localparam int TIMEOUT_CYC = RESET_CYC + INIT_BUDGET + 8 * N_OPS + 50;
    localparam int DRAIN_CYC   = 20;

    logic                mem_wr_if_in;
    logic                addr_reset;
    logic                wr_req;
    logic [ADDR_WID-1:0] wr_addr;
    logic [DATA_WID-1:0] wr_data;
    logic                rd_req;
    logic [ADDR_WID-1:0] rd_addr;
    logic                wr_ack;
    logic                rd_valid;
    logic [DATA_WID-1:0] rd_data;
    logic                ready;

    int                  err_cnt = 0;
    int                  reads_checked = 0;
    int                  acks_checked = 0;
    int                  edge_cnt = 0;
    logic                ready_seen = 1'b0;
    logic [31:0]         lcg_state = 32'hdded;

    // Reference contents and in-flight traffic
    logic [DATA_WID-1:0] ref_mem [2**ADDR_WID];
    int                  wr_edge_q [$];
    logic [ADDR_WID-1:0] wr_addr_q [$];
    logic [DATA_WID-1:0] wr_data_q [$];
    int                  ack_due_q [$];
    int                  rd_due_q [$];
    logic [ADDR_WID-1:0] rd_addr_q [$];
    logic [DATA_WID-1:0] rd_exp_q [$];

    tb_clock_gen #(
        .PERIOD_NS      (10),
        .RESET_CYCLES   (RESET_CYC)
    ) tb_clock_gen_inst (
        .clk            (mem_wr_if_in),
        .rst            (addr_reset)
    );

    mem_bank_array #(
        .OPT_MODE       (MODE)
    ) mem_bank_array_inst (
        .mem_wr_if_in   (mem_wr_if_in),
        .addr_reset     (addr_reset),
        .wr_req         (wr_req),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .rd_req         (rd_req),
        .rd_addr        (rd_addr),
        .wr_ack         (wr_ack),
        .rd_valid       (rd_valid),
        .rd_data        (rd_data),
        .ready          (ready)
    );

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [DATA_WID-1:0] ref_read(input logic [ADDR_WID-1:0] addr);
        return ref_mem[addr];
    endfunction

    // Commit writes old enough to be seen by a read sampled at rd_edge
    task automatic retire_writes(input int rd_edge);
        logic [ADDR_WID-1:0] a;
        logic [DATA_WID-1:0] d;
        while (wr_edge_q.size() > 0 && wr_edge_q[0] + RAW_GAP <= rd_edge) begin
            a = wr_addr_q.pop_front();
            d = wr_data_q.pop_front();
            void'(wr_edge_q.pop_front());
            ref_mem[a] = d;
        end
    endtask

    task automatic set_inputs(input logic do_wr, input logic [ADDR_WID-1:0] wa,
                              input logic [DATA_WID-1:0] wd, input logic do_rd,
                              input logic [ADDR_WID-1:0] ra);
        wr_req  = do_wr;
        wr_addr = wa;
        wr_data = wd;
        rd_req  = do_rd;
        rd_addr = ra;
    endtask

    task automatic drive_cycle(input logic do_wr, input logic [ADDR_WID-1:0] wa,
                               input logic [DATA_WID-1:0] wd, input logic do_rd,
                               input logic [ADDR_WID-1:0] ra);
        @(negedge mem_wr_if_in);
        set_inputs(do_wr, wa, wd, do_rd, ra);
    endtask

    task automatic wait_for_ready();
        int n;
        n = 0;
        while (!ready && n < INIT_BUDGET) begin
            @(negedge mem_wr_if_in);
            n++;
        end
        assert (ready) else begin
            err_cnt++;
            $display("%0t: ready did not rise within %0d cycles", $time, INIT_BUDGET);
        end
    endtask

    // ----------------------------------------
    // Capture of accepted requests
    // ----------------------------------------
    always @(posedge mem_wr_if_in) begin
        edge_cnt = edge_cnt + 1;
        if (!addr_reset && ready_seen) begin
            if (wr_req) begin
                wr_edge_q.push_back(edge_cnt);
                wr_addr_q.push_back(wr_addr);
                wr_data_q.push_back(wr_data);
                ack_due_q.push_back(edge_cnt + WR_ACK_LAT);
            end
            if (rd_req) begin
                retire_writes(edge_cnt);
                rd_due_q.push_back(edge_cnt + RD_LAT);
                rd_addr_q.push_back(rd_addr);
                rd_exp_q.push_back(ref_read(rd_addr));
            end
        end
    end

    // Outputs compared half a cycle after they change
    always @(negedge mem_wr_if_in) begin : compare
        logic                exp_ack;
        logic                exp_rd;
        logic [DATA_WID-1:0] exp_data;
        logic [ADDR_WID-1:0] exp_addr;
        if (!addr_reset) begin
            if (ready) begin
                ready_seen = 1'b1;
            end else begin
                assert (!ready_seen) else begin
                    err_cnt++;
                    $display("%0t: ready dropped after init", $time);
                end
                assert (!wr_ack && !rd_valid) else begin
                    err_cnt++;
                    $display("%0t: response seen while ready is low", $time);
                end
            end

            exp_ack = (ack_due_q.size() > 0) && (ack_due_q[0] == edge_cnt);
            assert (wr_ack == exp_ack) else begin
                err_cnt++;
                if (exp_ack)
                    $display("%0t: wr_ack missing at edge %0d", $time, edge_cnt);
                else
                    $display("%0t: unexpected wr_ack at edge %0d", $time, edge_cnt);
            end
            if (exp_ack) begin
                void'(ack_due_q.pop_front());
                acks_checked++;
            end

            exp_rd = (rd_due_q.size() > 0) && (rd_due_q[0] == edge_cnt);
            assert (rd_valid == exp_rd) else begin
                err_cnt++;
                if (exp_rd)
                    $display("%0t: rd_valid missing for read of %02h", $time, rd_addr_q[0]);
                else
                    $display("%0t: unexpected rd_valid with no read due", $time);
            end
            if (exp_rd) begin
                void'(rd_due_q.pop_front());
                exp_addr = rd_addr_q.pop_front();
                exp_data = rd_exp_q.pop_front();
                if (rd_valid) begin
                    assert (rd_data === exp_data) else begin
                        err_cnt++;
                        $display("MISMATCH t=%0t rd_data addr=%02h expected=%04h got=%04h",
                                 $time, exp_addr, exp_data, rd_data);
                    end
                    reads_checked++;
                end
            end
        end
    end

    initial begin : watchdog
        int n;
        n = 0;
        while (n < TIMEOUT_CYC) begin
            @(posedge mem_wr_if_in);
            n++;
        end
        $display("Timeout after %0d cycles, %0d errors so far", TIMEOUT_CYC, err_cnt);
        $display("TB FAILED");
        $finish;
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin : stimulus
        logic [31:0]         r;
        logic [31:0]         d;
        logic [ADDR_WID-1:0] a;
        int                  n;
        for (int i = 0; i < 2**ADDR_WID; i++) begin
            ref_mem[i] = RESET_VAL;
        end
        set_inputs(1'b0, '0, '0, 1'b0, '0);
        while (addr_reset !== 1'b0) @(negedge mem_wr_if_in);
        assert (!ready) else begin
            err_cnt++;
            $display("%0t: ready high right after reset", $time);
        end

        // Let the clear walk pass the low rows, so a leaked write would survive
        repeat (20) @(negedge mem_wr_if_in);

        // Requests during the clear walk are dropped
        for (int i = 0; i < N_DROP; i++) begin
            a = {2'(i), 6'(i)};
            drive_cycle(1'b1, a, 16'hbad0 + 16'(i), 1'b1, a);
        end
        drive_cycle(1'b0, '0, '0, 1'b0, '0);
        wait_for_ready();

        // Clear value across all banks, dropped addresses included
        for (int i = 0; i < N_CLEAR_RD; i++) begin
            drive_cycle(1'b0, '0, '0, 1'b1, 8'(i * 17));
        end
        for (int i = 0; i < N_DROP; i++) begin
            drive_cycle(1'b0, '0, '0, 1'b1, {2'(i), 6'(i)});
        end

        // Write, wait for its ack, read it back
        for (int i = 0; i < N_WR_RD; i++) begin
            r = next_rand();
            d = next_rand();
            a = {2'(i), r[29:24]};
            drive_cycle(1'b1, a, d[31:16], 1'b0, '0);
            drive_cycle(1'b0, '0, '0, 1'b0, '0);
            while (!wr_ack) @(negedge mem_wr_if_in);
            set_inputs(1'b0, '0, '0, 1'b1, a);
            drive_cycle(1'b0, '0, '0, 1'b0, '0);
        end

        // Back-to-back mixed traffic on a small address set
        for (int i = 0; i < N_MIX; i++) begin
            r = next_rand();
            d = next_rand();
            drive_cycle(r[31] | ~r[30], {r[29:28], 3'b000, r[27:25]}, d[31:16],
                        r[30], {r[24:23], 3'b000, r[22:20]});
        end
        drive_cycle(1'b0, '0, '0, 1'b0, '0);

        n = 0;
        while ((ack_due_q.size() + rd_due_q.size()) > 0 && n < DRAIN_CYC) begin
            @(posedge mem_wr_if_in);
            n++;
        end
        assert (ack_due_q.size() == 0 && rd_due_q.size() == 0) else begin
            err_cnt++;
            $display("%0t: responses still outstanding at end of run", $time);
        end

        $display("Summary: %0d errors, %0d reads checked, %0d write acks checked",
                 err_cnt, reads_checked, acks_checked);
        if (err_cnt == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule : tb_mem_bank_array

`default_nettype wire

//--- verilog.f
hw/mem_cfg_pkg.sv
hw/mem_ctrl_pkg.sv
hw/bank_dispatch.sv
hw/mem_reset_fsm.sv
hw/mem_bank.sv
hw/bank_merge.sv
hw/mem_bank_array.sv
verif/tb_clock_gen.sv
verif/tb_mem_bank_array.sv
